/* files.f */
verilog/thumb_ctrl_pkg.sv
verilog/reg_list_picker.sv
verilog/op_decoder.sv
verilog/block_transfer_seq.sv
verilog/thumb_ctrl_top.sv
tb/tb_clock_gen.sv
tb/thumb_ctrl_props.sv
tb/thumb_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module thumb_ctrl_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vthumb_ctrl_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // release lands 1 ns after an edge, like the rest of the stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

/* tb/thumb_ctrl_props.sv */
`timescale 1ns/1ps

module thumb_ctrl_props (
    input logic                       clk_i,
    input logic                       rst_n_i,
    input thumb_ctrl_pkg::instr_t     instr_i,
    input thumb_ctrl_pkg::ctrl_word_t ctrl_i,
    input logic                       stall_i
);

    // consecutive cycles with stall high so far
    logic [4:0] stall_run;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !stall_i) begin
            stall_run <= '0;
        end else begin
            stall_run <= stall_run + 5'd1;
        end
    end

    instr_held_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> $stable(instr_i))
        else $error("instr_i changed while stall_o was high");

    single_write_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |-> !(ctrl_i.mem_write && ctrl_i.reg_write))
        else $error("mem_write and reg_write both high during a block transfer");

    idle_after_reset_a: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !stall_i)
        else $error("stall_o high in the first cycle after reset");

    stall_bounded_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(stall_i && stall_run >= 5'd16))
        else $error("stall_o stayed high for more than 16 cycles");

endmodule

/* tb/thumb_ctrl_tb.sv */
`timescale 1ns/1ps

module thumb_ctrl_tb;

    typedef struct packed {
        logic [15:0]                 instr;
        thumb_ctrl_pkg::block_kind_e kind;
        thumb_ctrl_pkg::alu_op_e     alu_op;
        thumb_ctrl_pkg::alu_src_e    in2_sel;
        logic [3:0]                  flags;  // {in1 zero, reg_write, mem_write, update_flags}
    } row_t;

    localparam int TIMEOUT_CYCLES = 20;

    logic                       clk;
    logic                       rst_n;
    thumb_ctrl_pkg::instr_t     instr;
    thumb_ctrl_pkg::ctrl_word_t ctrl;
    logic                       stall;
    row_t                       rows[$];
    int                         check_count;
    int                         error_count;
    bit                         timed_out;

    tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    thumb_ctrl_top uut (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .instr_i (instr),
        .ctrl_o  (ctrl),
        .stall_o (stall)
    );

    bind block_transfer_seq thumb_ctrl_props u_props (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .instr_i (instr_i),
        .ctrl_i  (ctrl_o),
        .stall_i (stall_o)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic add_single(input logic [15:0] code, input thumb_ctrl_pkg::alu_op_e op,
                              input thumb_ctrl_pkg::alu_src_e in2, input logic [3:0] flags);
        row_t r;
        r = '{code, thumb_ctrl_pkg::BLK_NONE, op, in2, flags};
        rows.push_back(r);
    endtask

    task automatic add_block(input logic [15:0] code, input thumb_ctrl_pkg::block_kind_e kind);
        row_t r;
        r = '{code, kind, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_REG, 4'b0000};
        rows.push_back(r);
    endtask

    // low byte, plus LR for push and PC for pop from bit 8
    function automatic logic [15:0] transfer_list(input row_t r);
        logic [15:0] lst;
        lst = {8'h00, r.instr[7:0]};
        if (r.kind == thumb_ctrl_pkg::BLK_PUSH) lst[14] = r.instr[8];
        if (r.kind == thumb_ctrl_pkg::BLK_POP) lst[15] = r.instr[8];
        return lst;
    endfunction

    // new instruction 1 ns after the edge, outputs sampled 1 ns later
    task automatic drive_instr(input thumb_ctrl_pkg::instr_t code);
        @(posedge clk);
        #1;
        instr = code;
        #1;
    endtask

    task automatic run_single(input row_t r);
        thumb_ctrl_pkg::alu_src_e in1;
        in1 = r.flags[3] ? thumb_ctrl_pkg::SRC_ZERO : thumb_ctrl_pkg::SRC_REG;
        drive_instr(r.instr);
        check_value("stall_o", stall, 1'b0);
        check_value("alu_op", ctrl.alu_op, r.alu_op);
        check_value("alu_in1_sel", ctrl.alu_in1_sel, in1);
        check_value("alu_in2_sel", ctrl.alu_in2_sel, r.in2_sel);
        check_value("reg_write", ctrl.reg_write, r.flags[2]);
        check_value("mem_write", ctrl.mem_write, r.flags[1]);
        check_value("update_flags", ctrl.update_flags, r.flags[0]);
        check_value("reg_addr", ctrl.reg_addr, 4'd0);
        check_value("addr2_from_ctrl", ctrl.addr2_from_ctrl, 1'b0);
        check_value("dest_from_ctrl", ctrl.dest_from_ctrl, 1'b0);
        check_value("imm", ctrl.imm, 32'd0);
    endtask

    task automatic check_step(input thumb_ctrl_pkg::block_kind_e kind, input int reg_num,
                              input int n, input int k);
        logic        is_store;
        logic [31:0] imm;
        is_store = (kind == thumb_ctrl_pkg::BLK_PUSH || kind == thumb_ctrl_pkg::BLK_STM);
        case (kind)
            thumb_ctrl_pkg::BLK_PUSH: imm = 32'(4 * n - 4 * k);
            thumb_ctrl_pkg::BLK_LDM:  imm = 32'(4 * (n - 1) - 4 * k);
            default:                  imm = 32'(4 * k);
        endcase
        check_value("reg_addr", ctrl.reg_addr, reg_num);
        check_value("reg_write", ctrl.reg_write, !is_store);
        check_value("mem_write", ctrl.mem_write, is_store);
        check_value("addr2_from_ctrl", ctrl.addr2_from_ctrl, is_store);
        check_value("dest_from_ctrl", ctrl.dest_from_ctrl, !is_store);
        check_value("imm", ctrl.imm, imm);
        if (kind == thumb_ctrl_pkg::BLK_PUSH) begin
            check_value("alu_op", ctrl.alu_op, thumb_ctrl_pkg::ALU_SUB);
        end
    endtask

    task automatic check_final(input thumb_ctrl_pkg::block_kind_e kind, input logic [3:0] base,
                               input logic base_listed, input int n);
        logic [3:0] addr;
        logic       rw;
        addr = base;
        rw   = 1'b1;
        case (kind)
            thumb_ctrl_pkg::BLK_PUSH,
            thumb_ctrl_pkg::BLK_POP: addr = thumb_ctrl_pkg::SP_REG;
            thumb_ctrl_pkg::BLK_STM: check_value("dest_from_ctrl", ctrl.dest_from_ctrl, 1'b1);
            default: rw = !base_listed;
        endcase
        check_value("reg_addr", ctrl.reg_addr, addr);
        check_value("reg_write", ctrl.reg_write, rw);
        check_value("mem_write", ctrl.mem_write, 1'b0);
        check_value("imm", ctrl.imm, 32'(4 * n));
    endtask

    task automatic run_block(input row_t r);
        logic [15:0] lst;
        logic [3:0]  base;
        int          order[$];
        int          k;
        lst  = transfer_list(r);
        base = {1'b0, r.instr[10:8]};
        // ldm walks the list from the top
        for (int i = 0; i < 16; i++) begin
            if (lst[i] && r.kind == thumb_ctrl_pkg::BLK_LDM) order.push_front(i);
            else if (lst[i]) order.push_back(i);
        end
        k = 0;
        drive_instr(r.instr);
        while (stall && k < TIMEOUT_CYCLES) begin
            if (k < order.size()) check_step(r.kind, order[k], order.size(), k);
            else check_value("stall_o", stall, 1'b0);
            k++;
            @(posedge clk);
            #2;
        end
        if (stall) begin
            $display("Timeout: stall_o still high after %0d cycles for 0x%h", k, r.instr);
            error_count++;
            timed_out = 1'b1;
        end else begin
            check_value("stall_o high cycles", k, order.size());
            check_final(r.kind, base, lst[base], order.size());
        end
    endtask

    initial begin
        logic [8:0] body;
        int         waited;
        instr       = '0;
        check_count = 0;
        error_count = 0;
        timed_out   = 1'b0;
        void'($urandom(32'hfb9959e8));

        // shift, add, sub, move, compare
        add_single(16'h0088, thumb_ctrl_pkg::ALU_LSL, thumb_ctrl_pkg::SRC_IMM, 4'b0101);
        add_single(16'h1088, thumb_ctrl_pkg::ALU_ASR, thumb_ctrl_pkg::SRC_IMM, 4'b0101);
        add_single(16'h1888, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_REG, 4'b0101);
        add_single(16'h1E88, thumb_ctrl_pkg::ALU_SUB, thumb_ctrl_pkg::SRC_IMM, 4'b0101);
        add_single(16'h2012, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_IMM, 4'b1101);
        add_single(16'h2812, thumb_ctrl_pkg::ALU_SUB, thumb_ctrl_pkg::SRC_IMM, 4'b0001);
        add_single(16'h3012, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_IMM, 4'b0101);
        // data processing
        add_single(16'h400A, thumb_ctrl_pkg::ALU_AND, thumb_ctrl_pkg::SRC_REG, 4'b0101);
        add_single(16'h41CA, thumb_ctrl_pkg::ALU_ROR, thumb_ctrl_pkg::SRC_REG, 4'b0101);
        add_single(16'h420A, thumb_ctrl_pkg::ALU_AND, thumb_ctrl_pkg::SRC_REG, 4'b0001);
        add_single(16'h424A, thumb_ctrl_pkg::ALU_SUB, thumb_ctrl_pkg::SRC_REG, 4'b1101);
        add_single(16'h42CA, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_REG, 4'b0001);
        add_single(16'h434A, thumb_ctrl_pkg::ALU_MULT, thumb_ctrl_pkg::SRC_REG, 4'b0101);
        add_single(16'h43CA, thumb_ctrl_pkg::ALU_NOT, thumb_ctrl_pkg::SRC_REG, 4'b0101);
        // single loads and stores
        add_single(16'h5000, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_REG, 4'b0010);
        add_single(16'h5600, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_REG, 4'b0100);
        add_single(16'h5800, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_REG, 4'b0100);
        add_single(16'h6000, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_IMM, 4'b0010);
        add_single(16'h7800, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_IMM, 4'b0100);
        add_single(16'h8000, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_IMM, 4'b0010);
        add_single(16'h9800, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_IMM, 4'b0100);
        // dropped: branches, load literal, sign extend
        add_single(16'hD0FE, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_REG, 4'b0000);
        add_single(16'hE7FE, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_REG, 4'b0000);
        add_single(16'h4801, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_REG, 4'b0000);
        add_single(16'hB200, thumb_ctrl_pkg::ALU_ADD, thumb_ctrl_pkg::SRC_REG, 4'b0000);
        // block transfers, the first two back to back
        add_block(16'hB503, thumb_ctrl_pkg::BLK_PUSH);
        add_block(16'hBD10, thumb_ctrl_pkg::BLK_POP);
        add_block(16'hC229, thumb_ctrl_pkg::BLK_STM);
        add_block(16'hC906, thumb_ctrl_pkg::BLK_LDM);
        add_block(16'hC888, thumb_ctrl_pkg::BLK_LDM);
        add_block(16'hB400, thumb_ctrl_pkg::BLK_PUSH);
        add_block(16'hC800, thumb_ctrl_pkg::BLK_LDM);
        add_block(16'hB5FF, thumb_ctrl_pkg::BLK_PUSH);
        add_block(16'hBDFF, thumb_ctrl_pkg::BLK_POP);
        for (int i = 0; i < 12; i++) begin
            body = 9'($urandom);
            case ($urandom_range(3, 0))
                0: add_block({7'b1011010, body}, thumb_ctrl_pkg::BLK_PUSH);
                1: add_block({7'b1011110, body}, thumb_ctrl_pkg::BLK_POP);
                2: add_block({5'b11000, 3'($urandom), body[7:0]}, thumb_ctrl_pkg::BLK_STM);
                default: add_block({5'b11001, 3'($urandom), body[7:0]}, thumb_ctrl_pkg::BLK_LDM);
            endcase
        end

        waited = 0;
        while (rst_n !== 1'b1 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            error_count++;
            timed_out = 1'b1;
        end

        foreach (rows[i]) begin
            if (timed_out) break;
            if (rows[i].kind == thumb_ctrl_pkg::BLK_NONE) run_single(rows[i]);
            else run_block(rows[i]);
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verilog/block_transfer_seq.sv */
`timescale 1ns/1ps

module block_transfer_seq (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  thumb_ctrl_pkg::instr_t      instr_i,
    input  thumb_ctrl_pkg::block_kind_e kind_i,
    output thumb_ctrl_pkg::ctrl_word_t  ctrl_o,
    output logic                        stall_o
);

    logic [thumb_ctrl_pkg::LIST_W-1:0]     reg_list;
    logic [thumb_ctrl_pkg::LIST_W-1:0]     mask_q;
    logic [thumb_ctrl_pkg::LIST_W-1:0]     pick;
    logic [thumb_ctrl_pkg::REG_ADDR_W-1:0] pick_num;
    logic [thumb_ctrl_pkg::COUNT_W-1:0]    remaining;
    logic [thumb_ctrl_pkg::COUNT_W-1:0]    total;
    logic [thumb_ctrl_pkg::COUNT_W-1:0]    step_q;
    logic [thumb_ctrl_pkg::WORD-1:0]       n_bytes;
    logic [thumb_ctrl_pkg::WORD-1:0]       k_bytes;
    logic [thumb_ctrl_pkg::REG_ADDR_W-1:0] base_reg;
    logic                                  base_in_list;
    logic                                  highest_first;

    always_comb begin
        reg_list = '0;
        case (kind_i)
            thumb_ctrl_pkg::BLK_PUSH: begin
                reg_list[7:0]                  = instr_i[7:0];
                reg_list[thumb_ctrl_pkg::LR_REG] = instr_i[8];
            end
            thumb_ctrl_pkg::BLK_POP: begin
                reg_list[7:0]                  = instr_i[7:0];
                reg_list[thumb_ctrl_pkg::PC_REG] = instr_i[8];
            end
            thumb_ctrl_pkg::BLK_STM,
            thumb_ctrl_pkg::BLK_LDM: reg_list[7:0] = instr_i[7:0];
            default: ;
        endcase
    end

    // ldm walks down so the offsets count from the top of the block
    assign highest_first = (kind_i == thumb_ctrl_pkg::BLK_LDM);

    reg_list_picker u_picker (
        .list_i          (reg_list),
        .mask_i          (mask_q),
        .highest_first_i (highest_first),
        .pick_o          (pick),
        .reg_num_o       (pick_num),
        .remaining_o     (remaining),
        .total_o         (total)
    );

    assign stall_o = (remaining != '0);

    assign base_reg     = {1'b0, instr_i[10:8]};
    assign base_in_list = instr_i[instr_i[10:8]];

    assign n_bytes = {{(thumb_ctrl_pkg::WORD - thumb_ctrl_pkg::COUNT_W - 2){1'b0}}, total, 2'b00};
    assign k_bytes = {{(thumb_ctrl_pkg::WORD - thumb_ctrl_pkg::COUNT_W - 2){1'b0}}, step_q, 2'b00};

    always_comb begin
        ctrl_o = thumb_ctrl_pkg::CTRL_DEFAULT;
        if (kind_i != thumb_ctrl_pkg::BLK_NONE) begin
            ctrl_o.alu_in2_sel = thumb_ctrl_pkg::SRC_ACC;
            ctrl_o.reg_addr    = stall_o ? pick_num : base_reg;
        end
        case (kind_i)
            thumb_ctrl_pkg::BLK_PUSH: begin
                ctrl_o.alu_op          = thumb_ctrl_pkg::ALU_SUB;
                ctrl_o.addr2_from_ctrl = 1'b1;
                ctrl_o.mem_write       = stall_o;
                ctrl_o.reg_write       = !stall_o;
                ctrl_o.imm             = stall_o ? n_bytes - k_bytes : n_bytes;
                if (!stall_o) begin
                    ctrl_o.reg_addr = thumb_ctrl_pkg::SP_REG;
                end
            end
            thumb_ctrl_pkg::BLK_POP: begin
                ctrl_o.dest_from_ctrl = 1'b1;
                ctrl_o.reg_write      = 1'b1;
                ctrl_o.imm            = stall_o ? k_bytes : n_bytes;
                if (!stall_o) begin
                    ctrl_o.reg_addr = thumb_ctrl_pkg::SP_REG;
                end
            end
            thumb_ctrl_pkg::BLK_STM: begin
                ctrl_o.addr2_from_ctrl = stall_o;
                ctrl_o.dest_from_ctrl  = !stall_o;
                ctrl_o.mem_write       = stall_o;
                ctrl_o.reg_write       = !stall_o;
                ctrl_o.imm             = stall_o ? k_bytes : n_bytes;
            end
            thumb_ctrl_pkg::BLK_LDM: begin
                ctrl_o.dest_from_ctrl = 1'b1;
                // base write-back would clobber a freshly loaded base
                ctrl_o.reg_write      = stall_o || !base_in_list;
                ctrl_o.imm            = stall_o ? n_bytes - thumb_ctrl_pkg::WORD_BYTES - k_bytes
                                                : n_bytes;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !stall_o) begin
            mask_q <= '1;
            step_q <= '0;
        end else begin
            mask_q <= mask_q & ~pick;
            step_q <= step_q + thumb_ctrl_pkg::COUNT_ONE;
        end
    end

endmodule

/* verilog/op_decoder.sv */
`timescale 1ns/1ps

module op_decoder (
    input  thumb_ctrl_pkg::instr_t      instr_i,
    input  thumb_ctrl_pkg::ctrl_word_t  seq_ctrl_i,
    output thumb_ctrl_pkg::block_kind_e kind_o,
    output thumb_ctrl_pkg::ctrl_word_t  ctrl_o
);

    thumb_ctrl_pkg::ctrl_word_t dec_ctrl;

    always_comb begin
        dec_ctrl = thumb_ctrl_pkg::CTRL_DEFAULT;
        kind_o   = thumb_ctrl_pkg::BLK_NONE;

        casez (instr_i[15:10])
            thumb_ctrl_pkg::OP_SHIFT_IMM: begin
                dec_ctrl.update_flags = 1'b1;
                dec_ctrl.reg_write    = 1'b1;
                casez (instr_i[13:9])
                    thumb_ctrl_pkg::SH_LSL_IMM: begin
                        dec_ctrl.alu_op      = thumb_ctrl_pkg::ALU_LSL;
                        dec_ctrl.alu_in2_sel = thumb_ctrl_pkg::SRC_IMM;
                    end
                    thumb_ctrl_pkg::SH_LSR_IMM: begin
                        dec_ctrl.alu_op      = thumb_ctrl_pkg::ALU_LSR;
                        dec_ctrl.alu_in2_sel = thumb_ctrl_pkg::SRC_IMM;
                    end
                    thumb_ctrl_pkg::SH_ASR_IMM: begin
                        dec_ctrl.alu_op      = thumb_ctrl_pkg::ALU_ASR;
                        dec_ctrl.alu_in2_sel = thumb_ctrl_pkg::SRC_IMM;
                    end
                    thumb_ctrl_pkg::SH_ADD_REG: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_ADD;
                    thumb_ctrl_pkg::SH_SUB_REG: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_SUB;
                    thumb_ctrl_pkg::SH_ADD_IMM3,
                    thumb_ctrl_pkg::SH_ADD_IMM8: begin
                        dec_ctrl.alu_in2_sel = thumb_ctrl_pkg::SRC_IMM;
                    end
                    thumb_ctrl_pkg::SH_SUB_IMM3,
                    thumb_ctrl_pkg::SH_SUB_IMM8: begin
                        dec_ctrl.alu_op      = thumb_ctrl_pkg::ALU_SUB;
                        dec_ctrl.alu_in2_sel = thumb_ctrl_pkg::SRC_IMM;
                    end
                    // move is 0 + imm
                    thumb_ctrl_pkg::SH_MOV_IMM8: begin
                        dec_ctrl.alu_in1_sel = thumb_ctrl_pkg::SRC_ZERO;
                        dec_ctrl.alu_in2_sel = thumb_ctrl_pkg::SRC_IMM;
                    end
                    thumb_ctrl_pkg::SH_CMP_IMM8: begin
                        dec_ctrl.alu_op      = thumb_ctrl_pkg::ALU_SUB;
                        dec_ctrl.alu_in2_sel = thumb_ctrl_pkg::SRC_IMM;
                        dec_ctrl.reg_write   = 1'b0;
                    end
                    default: ;
                endcase
            end
            thumb_ctrl_pkg::OP_DATA_PROC: begin
                dec_ctrl.update_flags = 1'b1;
                dec_ctrl.reg_write    = 1'b1;
                case (instr_i[9:6])
                    thumb_ctrl_pkg::DP_AND: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_AND;
                    thumb_ctrl_pkg::DP_EOR: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_XOR;
                    thumb_ctrl_pkg::DP_LSL: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_LSL;
                    thumb_ctrl_pkg::DP_LSR: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_LSR;
                    thumb_ctrl_pkg::DP_ASR: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_ASR;
                    thumb_ctrl_pkg::DP_ADC: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_ADD;
                    thumb_ctrl_pkg::DP_SBC: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_SUB;
                    thumb_ctrl_pkg::DP_ROR: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_ROR;
                    thumb_ctrl_pkg::DP_TST: begin
                        dec_ctrl.alu_op    = thumb_ctrl_pkg::ALU_AND;
                        dec_ctrl.reg_write = 1'b0;
                    end
                    // negate as 0 - rm
                    thumb_ctrl_pkg::DP_RSB: begin
                        dec_ctrl.alu_op      = thumb_ctrl_pkg::ALU_SUB;
                        dec_ctrl.alu_in1_sel = thumb_ctrl_pkg::SRC_ZERO;
                    end
                    thumb_ctrl_pkg::DP_CMP: begin
                        dec_ctrl.alu_op    = thumb_ctrl_pkg::ALU_SUB;
                        dec_ctrl.reg_write = 1'b0;
                    end
                    thumb_ctrl_pkg::DP_CMN: begin
                        dec_ctrl.alu_op    = thumb_ctrl_pkg::ALU_ADD;
                        dec_ctrl.reg_write = 1'b0;
                    end
                    thumb_ctrl_pkg::DP_ORR: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_OR;
                    thumb_ctrl_pkg::DP_MUL: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_MULT;
                    thumb_ctrl_pkg::DP_BIC: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_BIC;
                    thumb_ctrl_pkg::DP_MVN: dec_ctrl.alu_op = thumb_ctrl_pkg::ALU_NOT;
                    default: ;
                endcase
            end
            // loads are bit 11 or the signed forms with sub-code 11
            thumb_ctrl_pkg::OP_LS_REG: begin
                if (instr_i[11] || instr_i[10:9] == 2'b11) begin
                    dec_ctrl.reg_write = 1'b1;
                end else begin
                    dec_ctrl.mem_write = 1'b1;
                end
            end
            thumb_ctrl_pkg::OP_LS_IMM,
            thumb_ctrl_pkg::OP_LS_HW,
            thumb_ctrl_pkg::OP_LS_SP: begin
                dec_ctrl.alu_in2_sel = thumb_ctrl_pkg::SRC_IMM;
                if (instr_i[11]) begin
                    dec_ctrl.reg_write = 1'b1;
                end else begin
                    dec_ctrl.mem_write = 1'b1;
                end
            end
            thumb_ctrl_pkg::OP_MISC: begin
                casez (instr_i[11:5])
                    thumb_ctrl_pkg::MISC_PUSH: kind_o = thumb_ctrl_pkg::BLK_PUSH;
                    thumb_ctrl_pkg::MISC_POP:  kind_o = thumb_ctrl_pkg::BLK_POP;
                    default: ;
                endcase
            end
            thumb_ctrl_pkg::OP_STM: kind_o = thumb_ctrl_pkg::BLK_STM;
            thumb_ctrl_pkg::OP_LDM: kind_o = thumb_ctrl_pkg::BLK_LDM;
            default: ;
        endcase
    end

    assign ctrl_o = (kind_o == thumb_ctrl_pkg::BLK_NONE) ? dec_ctrl : seq_ctrl_i;

endmodule

/* verilog/reg_list_picker.sv */
`timescale 1ns/1ps

module reg_list_picker (
    input  logic [thumb_ctrl_pkg::LIST_W-1:0]     list_i,
    input  logic [thumb_ctrl_pkg::LIST_W-1:0]     mask_i,
    input  logic                                  highest_first_i,
    output logic [thumb_ctrl_pkg::LIST_W-1:0]     pick_o,
    output logic [thumb_ctrl_pkg::REG_ADDR_W-1:0] reg_num_o,
    output logic [thumb_ctrl_pkg::COUNT_W-1:0]    remaining_o,
    output logic [thumb_ctrl_pkg::COUNT_W-1:0]    total_o
);

    logic [thumb_ctrl_pkg::LIST_W-1:0]     masked;
    logic [thumb_ctrl_pkg::REG_ADDR_W-1:0] lo_num;
    logic [thumb_ctrl_pkg::REG_ADDR_W-1:0] hi_num;
    logic                                  lo_found;

    assign masked = list_i & mask_i;

    always_comb begin
        lo_num      = '0;
        hi_num      = '0;
        lo_found    = 1'b0;
        remaining_o = '0;
        total_o     = '0;
        // the last set bit seen is the highest, the first one the lowest
        for (int i = 0; i < thumb_ctrl_pkg::LIST_W; i++) begin
            if (masked[i]) begin
                remaining_o = remaining_o + thumb_ctrl_pkg::COUNT_ONE;
                hi_num      = i[thumb_ctrl_pkg::REG_ADDR_W-1:0];
                if (!lo_found) begin
                    lo_num   = i[thumb_ctrl_pkg::REG_ADDR_W-1:0];
                    lo_found = 1'b1;
                end
            end
            if (list_i[i]) begin
                total_o = total_o + thumb_ctrl_pkg::COUNT_ONE;
            end
        end
    end

    assign reg_num_o = highest_first_i ? hi_num : lo_num;

    always_comb begin
        pick_o = '0;
        if (lo_found) begin
            pick_o[reg_num_o] = 1'b1;
        end
    end

endmodule

/* verilog/thumb_ctrl_pkg.sv */
package thumb_ctrl_pkg;

    localparam int WORD       = 32;
    localparam int REG_ADDR_W = 4;
    localparam int LIST_W     = 16;
    localparam int COUNT_W    = 5;

    localparam logic [REG_ADDR_W-1:0] SP_REG = 4'd13;
    localparam logic [REG_ADDR_W-1:0] LR_REG = 4'd14;
    localparam logic [REG_ADDR_W-1:0] PC_REG = 4'd15;

    localparam logic [COUNT_W-1:0] COUNT_ONE  = 5'd1;
    localparam logic [WORD-1:0]    WORD_BYTES = 32'd4;

    typedef logic [15:0] instr_t;

    // group patterns on instr[15:10]
    localparam logic [5:0] OP_SHIFT_IMM = 6'b00????;
    localparam logic [5:0] OP_DATA_PROC = 6'b010000;
    localparam logic [5:0] OP_LS_REG    = 6'b0101??;
    localparam logic [5:0] OP_LS_IMM    = 6'b011???;
    localparam logic [5:0] OP_LS_HW     = 6'b1000??;
    localparam logic [5:0] OP_LS_SP     = 6'b1001??;
    localparam logic [5:0] OP_MISC      = 6'b1011??;
    localparam logic [5:0] OP_STM       = 6'b11000?;
    localparam logic [5:0] OP_LDM       = 6'b11001?;

    // shift, add, sub, move, compare on instr[13:9]
    localparam logic [4:0] SH_LSL_IMM  = 5'b000??;
    localparam logic [4:0] SH_LSR_IMM  = 5'b001??;
    localparam logic [4:0] SH_ASR_IMM  = 5'b010??;
    localparam logic [4:0] SH_ADD_REG  = 5'b01100;
    localparam logic [4:0] SH_SUB_REG  = 5'b01101;
    localparam logic [4:0] SH_ADD_IMM3 = 5'b01110;
    localparam logic [4:0] SH_SUB_IMM3 = 5'b01111;
    localparam logic [4:0] SH_MOV_IMM8 = 5'b100??;
    localparam logic [4:0] SH_CMP_IMM8 = 5'b101??;
    localparam logic [4:0] SH_ADD_IMM8 = 5'b110??;
    localparam logic [4:0] SH_SUB_IMM8 = 5'b111??;

    // data-processing opcodes on instr[9:6]
    localparam logic [3:0] DP_AND = 4'b0000;
    localparam logic [3:0] DP_EOR = 4'b0001;
    localparam logic [3:0] DP_LSL = 4'b0010;
    localparam logic [3:0] DP_LSR = 4'b0011;
    localparam logic [3:0] DP_ASR = 4'b0100;
    localparam logic [3:0] DP_ADC = 4'b0101;
    localparam logic [3:0] DP_SBC = 4'b0110;
    localparam logic [3:0] DP_ROR = 4'b0111;
    localparam logic [3:0] DP_TST = 4'b1000;
    localparam logic [3:0] DP_RSB = 4'b1001;
    localparam logic [3:0] DP_CMP = 4'b1010;
    localparam logic [3:0] DP_CMN = 4'b1011;
    localparam logic [3:0] DP_ORR = 4'b1100;
    localparam logic [3:0] DP_MUL = 4'b1101;
    localparam logic [3:0] DP_BIC = 4'b1110;
    localparam logic [3:0] DP_MVN = 4'b1111;

    // misc group on instr[11:5]
    localparam logic [6:0] MISC_PUSH = 7'b010????;
    localparam logic [6:0] MISC_POP  = 7'b110????;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOT, ALU_BIC, ALU_MULT,
        ALU_LSL, ALU_LSR, ALU_ASR, ALU_ROR
    } alu_op_e;

    typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_ZERO, SRC_ACC} alu_src_e;

    typedef enum logic [2:0] {BLK_NONE, BLK_PUSH, BLK_POP, BLK_STM, BLK_LDM} block_kind_e;

    typedef struct packed {
        logic                  update_flags;
        logic                  reg_write;
        logic                  mem_write;
        alu_src_e              alu_in1_sel;
        alu_src_e              alu_in2_sel;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] reg_addr;
        logic                  addr2_from_ctrl;
        logic                  dest_from_ctrl;
        logic [WORD-1:0]       imm;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_DEFAULT = '{
        update_flags: 1'b0, reg_write: 1'b0, mem_write: 1'b0,
        alu_in1_sel: SRC_REG, alu_in2_sel: SRC_REG, alu_op: ALU_ADD,
        reg_addr: '0, addr2_from_ctrl: 1'b0, dest_from_ctrl: 1'b0, imm: '0
    };

endpackage

/* verilog/thumb_ctrl_top.sv */
`timescale 1ns/1ps

module thumb_ctrl_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  thumb_ctrl_pkg::instr_t     instr_i,
    output thumb_ctrl_pkg::ctrl_word_t ctrl_o,
    output logic                       stall_o
);

    // sequencer word, only forwarded for block transfers
    thumb_ctrl_pkg::ctrl_word_t  seq_ctrl;
    thumb_ctrl_pkg::block_kind_e kind;

    op_decoder u_decoder (
        .instr_i    (instr_i),
        .seq_ctrl_i (seq_ctrl),
        .kind_o     (kind),
        .ctrl_o     (ctrl_o)
    );

    block_transfer_seq u_seq (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .instr_i (instr_i),
        .kind_i  (kind),
        .ctrl_o  (seq_ctrl),
        .stall_o (stall_o)
    );

endmodule
